// ==== src/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

  // ##################################################
  // Widths and basic types
  // ##################################################

  localparam int IMEM_WORDS = 256;
  localparam int IMEM_AW    = $clog2(IMEM_WORDS);

  typedef logic [31:0] xlen_t;
  typedef logic [31:0] addr_t;
  typedef logic [31:0] inst_t;
  typedef logic [4:0]  reg_idx_t;

  // RV32I major opcodes.
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  typedef enum logic [2:0] {
    CLS_ALU,
    CLS_LOAD,
    CLS_STORE,
    CLS_BRANCH,
    CLS_JAL,
    CLS_JALR,
    CLS_SYSTEM,
    CLS_ILLEGAL
  } inst_class_e;

  // ##################################################
  // Bus and pipeline structs
  // ##################################################

  typedef struct packed {
    logic  req;
    logic  write;
    addr_t addr;
    xlen_t data;
  } instbus_req_s;

  typedef struct packed {
    logic  ack;
    addr_t addr;
    inst_t data;
  } instbus_rsp_s;

  typedef struct packed {
    logic        vld;
    addr_t       pc;
    inst_t       inst;
    inst_class_e cls;
    reg_idx_t    rd;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    xlen_t       imm;
  } predec_s;

endpackage

`default_nettype wire

// ==== src/riscv_ifu.sv ====
`default_nettype none

module riscv_ifu
  import fetch_pkg::*;
(
  input  logic         clk,
  input  logic         rst,

  input  logic         i_alu_vld,
  input  logic         i_alu_br_miss,
  input  addr_t        i_pc_in,

  output instbus_req_s o_instbus,
  input  instbus_rsp_s i_instbus,

  output logic         o_ifu_vld,
  output inst_t        o_ifu_inst,
  output addr_t        o_ifu_pc
);

  logic  idle;
  addr_t redir_pc;
  addr_t redir_pc_next;

  // ##################################################
  // Request side
  // ##################################################

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      idle          <= 1'b1;
      redir_pc      <= '0;
      redir_pc_next <= '0;
      o_instbus     <= '0;
    end
    else
    begin
      o_instbus.req <= 1'b0;

      // Redirect target follows the execute stage on a miss.
      if (i_alu_vld && i_alu_br_miss)
      begin
        redir_pc_next <= i_pc_in;
      end
      else
      begin
        redir_pc_next <= redir_pc + 32'd4;
      end

      if (i_alu_vld)
      begin
        if (i_instbus.ack || idle)
        begin
          idle            <= 1'b0;
          o_instbus.req   <= 1'b1;
          o_instbus.write <= 1'b0;
          o_instbus.data  <= '0;
          o_instbus.addr  <= i_alu_br_miss ? redir_pc : i_pc_in;
          redir_pc        <= redir_pc_next;
        end
      end
      else if (i_instbus.ack)
      begin
        // A frozen pipe restarts from idle once it thaws.
        idle <= 1'b1;
      end
    end
  end

  // ##################################################
  // Response side
  // ##################################################

  always_ff @(posedge clk)
  begin
    if (i_instbus.ack)
    begin
      o_ifu_inst <= i_instbus.data;
      o_ifu_pc   <= i_instbus.addr;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      o_ifu_vld <= 1'b0;
    end
    else
    begin
      // Squash the returning word on a miss.
      o_ifu_vld <= i_instbus.ack && !i_alu_br_miss;
    end
  end

  // Only one request in flight at a time.
  a_req_pulse : assert property (
    @(posedge clk) disable iff (rst) o_instbus.req |=> !o_instbus.req
  );

  a_no_write : assert property (
    @(posedge clk) disable iff (rst) !o_instbus.write
  );

endmodule

`default_nettype wire

// ==== src/inst_mem.sv ====
`default_nettype none

module inst_mem
  import fetch_pkg::*;
(
  input  logic         clk,
  input  logic         rst,

  input  logic         i_load_we,
  input  addr_t        i_load_addr,
  input  inst_t        i_load_data,

  input  instbus_req_s i_bus,
  output instbus_rsp_s o_bus
);

  inst_t mem [IMEM_WORDS];

  logic [IMEM_AW-1:0] load_idx;
  logic [IMEM_AW-1:0] bus_idx;

  // Word index drops the byte offset and ignores the upper bits.
  assign load_idx = i_load_addr[IMEM_AW+1:2];
  assign bus_idx  = i_bus.addr[IMEM_AW+1:2];

  // ##################################################
  // Storage
  // ##################################################

  always_ff @(posedge clk)
  begin
    if (i_load_we)
    begin
      mem[load_idx] <= i_load_data;
    end
  end

  // ##################################################
  // Read port
  // ##################################################

  always_ff @(posedge clk)
  begin
    if (i_bus.req)
    begin
      o_bus.addr <= i_bus.addr;
      o_bus.data <= mem[bus_idx];
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      o_bus.ack <= 1'b0;
    end
    else
    begin
      o_bus.ack <= i_bus.req;
    end
  end

  a_ack_after_req : assert property (
    @(posedge clk) disable iff (rst) o_bus.ack |-> $past(i_bus.req)
  );

endmodule

`default_nettype wire

// ==== src/riscv_predecode.sv ====
`default_nettype none

module riscv_predecode
  import fetch_pkg::*;
(
  input  logic    clk,
  input  logic    rst,

  input  logic    i_vld,
  input  inst_t   i_inst,
  input  addr_t   i_pc,

  output predec_s o_predec
);

  logic [6:0]  opcode;
  inst_class_e cls;
  xlen_t       imm_i;
  xlen_t       imm_s;
  xlen_t       imm_b;
  xlen_t       imm_u;
  xlen_t       imm_j;
  xlen_t       imm;

  assign opcode = i_inst[6:0];

  // ##################################################
  // Immediate formats
  // ##################################################

  assign imm_i = {{20{i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{19{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25],
                  i_inst[11:8], 1'b0};
  assign imm_u = {i_inst[31:12], 12'h000};
  assign imm_j = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20],
                  i_inst[30:21], 1'b0};

  // ##################################################
  // Class and immediate select
  // ##################################################

  always_comb
  begin
    cls = CLS_ILLEGAL;
    imm = '0;
    case (opcode)
      OPC_LUI, OPC_AUIPC:
      begin
        cls = CLS_ALU;
        imm = imm_u;
      end
      OPC_OPIMM:
      begin
        cls = CLS_ALU;
        imm = imm_i;
      end
      OPC_OP:
      begin
        // Register-register ops carry no immediate.
        cls = CLS_ALU;
      end
      OPC_LOAD:
      begin
        cls = CLS_LOAD;
        imm = imm_i;
      end
      OPC_STORE:
      begin
        cls = CLS_STORE;
        imm = imm_s;
      end
      OPC_BRANCH:
      begin
        cls = CLS_BRANCH;
        imm = imm_b;
      end
      OPC_JAL:
      begin
        cls = CLS_JAL;
        imm = imm_j;
      end
      OPC_JALR:
      begin
        cls = CLS_JALR;
        imm = imm_i;
      end
      OPC_SYSTEM:
      begin
        cls = CLS_SYSTEM;
        imm = imm_i;
      end
      default:
      begin
        cls = CLS_ILLEGAL;
      end
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (i_vld)
    begin
      o_predec.pc   <= i_pc;
      o_predec.inst <= i_inst;
      o_predec.cls  <= cls;
      o_predec.rd   <= i_inst[11:7];
      o_predec.rs1  <= i_inst[19:15];
      o_predec.rs2  <= i_inst[24:20];
      o_predec.imm  <= imm;
    end
    if (rst)
    begin
      o_predec.vld <= 1'b0;
    end
    else
    begin
      o_predec.vld <= i_vld;
    end
  end

endmodule

`default_nettype wire

// ==== src/fetch_top.sv ====
`default_nettype none

module fetch_top
  import fetch_pkg::*;
(
  input  logic    clk,
  input  logic    rst,

  input  logic    i_load_we,
  input  addr_t   i_load_addr,
  input  inst_t   i_load_data,

  input  logic    i_alu_vld,
  input  logic    i_alu_br_miss,
  input  addr_t   i_pc_next,

  output logic    o_ifu_vld,
  output inst_t   o_ifu_inst,
  output addr_t   o_ifu_pc,

  output predec_s o_predec
);

  instbus_req_s instbus_req;
  instbus_rsp_s instbus_rsp;

  inst_mem u_imem (
    .clk         (clk),
    .rst         (rst),
    .i_load_we   (i_load_we),
    .i_load_addr (i_load_addr),
    .i_load_data (i_load_data),
    .i_bus       (instbus_req),
    .o_bus       (instbus_rsp)
  );

  riscv_ifu u_ifu (
    .clk           (clk),
    .rst           (rst),
    .i_alu_vld     (i_alu_vld),
    .i_alu_br_miss (i_alu_br_miss),
    .i_pc_in       (i_pc_next),
    .o_instbus     (instbus_req),
    .i_instbus     (instbus_rsp),
    .o_ifu_vld     (o_ifu_vld),
    .o_ifu_inst    (o_ifu_inst),
    .o_ifu_pc      (o_ifu_pc)
  );

  riscv_predecode u_predec (
    .clk      (clk),
    .rst      (rst),
    .i_vld    (o_ifu_vld),
    .i_inst   (o_ifu_inst),
    .i_pc     (o_ifu_pc),
    .o_predec (o_predec)
  );

endmodule

`default_nettype wire

// ==== testbench/tb_clkgen.sv ====
`default_nettype none

module tb_clkgen
(
  output logic o_clk,
  output logic o_rst
);

  localparam int HALF_PERIOD  = 5;
  localparam int RESET_CYCLES = 10;

  initial
  begin
    o_clk = 1'b0;
    forever #HALF_PERIOD o_clk = ~o_clk;
  end

  initial
  begin
    o_rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge o_clk);
    o_rst <= 1'b0;
  end

endmodule

`default_nettype wire

// ==== testbench/tb_fetch.sv ====
`default_nettype none

module tb_fetch
  import fetch_pkg::*;
();

  localparam int          PROG_LEN        = 16;
  localparam int          NUM_TESTS       = 5;
  localparam int          CLK_PERIOD      = 10;
  localparam int          WATCHDOG_CYCLES = 60 * PROG_LEN * NUM_TESTS;
  localparam logic [31:0] SEED            = 32'hcc8b19e5;
  localparam addr_t       PARK_PC         = 32'h0000_0300;

  typedef struct packed {
    inst_t       inst;
    inst_class_e cls;
    xlen_t       imm;
  } prog_entry_s;

  typedef struct packed {
    addr_t       pc;
    logic        any_pc;
    logic [31:0] due;
  } fetch_exp_s;

  logic        clk;
  logic        rst;
  logic        load_we;
  addr_t       load_addr;
  inst_t       load_data;
  logic        alu_vld;
  logic        alu_br_miss;
  addr_t       pc_next;
  logic        ifu_vld;
  inst_t       ifu_inst;
  addr_t       ifu_pc;
  predec_s     predec;

  prog_entry_s prog [PROG_LEN];
  fetch_exp_s  exp_q [$];
  logic [31:0] cyc = '0;
  logic [31:0] lfsr = SEED;
  logic        prev_vld = 1'b0;
  addr_t       prev_pc;
  inst_t       prev_inst;
  int          errors = 0;
  int          fetches = 0;
  int          predecs = 0;

  tb_clkgen u_clkgen (
    .o_clk (clk),
    .o_rst (rst)
  );

  fetch_top u_dut (
    .clk           (clk),
    .rst           (rst),
    .i_load_we     (load_we),
    .i_load_addr   (load_addr),
    .i_load_data   (load_data),
    .i_alu_vld     (alu_vld),
    .i_alu_br_miss (alu_br_miss),
    .i_pc_next     (pc_next),
    .o_ifu_vld     (ifu_vld),
    .o_ifu_inst    (ifu_inst),
    .o_ifu_pc      (ifu_pc),
    .o_predec      (predec)
  );

  always @(posedge clk)
  begin
    cyc <= cyc + 1;
  end

  // ##################################################
  // Program table and reference memory image
  // ##################################################

  task automatic build_program();
    prog[0]  = '{32'h00500093, CLS_ALU,     32'h0000_0005};  // addi x1, x0, 5
    prog[1]  = '{32'h12345137, CLS_ALU,     32'h1234_5000};  // lui x2
    prog[2]  = '{32'hfffff197, CLS_ALU,     32'hffff_f000};  // auipc x3
    prog[3]  = '{32'h00208233, CLS_ALU,     32'h0000_0000};  // add x4, x1, x2
    prog[4]  = '{32'hffc0a283, CLS_LOAD,    32'hffff_fffc};  // lw x5, -4(x1)
    prog[5]  = '{32'h0020a423, CLS_STORE,   32'h0000_0008};  // sw x2, 8(x1)
    prog[6]  = '{32'hfe312623, CLS_STORE,   32'hffff_ffec};  // sw x3, -20(x2)
    prog[7]  = '{32'h00208863, CLS_BRANCH,  32'h0000_0010};  // beq x1, x2, 16
    prog[8]  = '{32'hfe021ce3, CLS_BRANCH,  32'hffff_fff8};  // bne x4, x0, -8
    prog[9]  = '{32'h001000ef, CLS_JAL,     32'h0000_0800};  // jal x1, 2048
    prog[10] = '{32'hffdff06f, CLS_JAL,     32'hffff_fffc};  // jal x0, -4
    prog[11] = '{32'h00008067, CLS_JALR,    32'h0000_0000};  // jalr x0, 0(x1)
    prog[12] = '{32'hc00022f3, CLS_SYSTEM,  32'hffff_fc00};  // csrrs x5, cycle
    prog[13] = '{32'habcde58b, CLS_ILLEGAL, 32'h0000_0000};  // custom-0 opcode
    prog[14] = '{32'hfff2f313, CLS_ALU,     32'hffff_ffff};  // andi x6, x5, -1
    prog[15] = '{32'h405303b3, CLS_ALU,     32'h0000_0000};  // sub x7, x6, x5
  endtask

  function automatic inst_t fill_word(input addr_t addr);
    return (addr * 32'h9e3779b1) ^ 32'h0000_0013;
  endfunction

  // Upper address bits alias onto the same word.
  function automatic inst_t word_at(input addr_t addr);
    logic [IMEM_AW-1:0] idx;
    idx = addr[IMEM_AW+1:2];
    if (idx < PROG_LEN)
    begin
      return prog[idx].inst;
    end
    return fill_word(addr_t'(idx) << 2);
  endfunction

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic int take_bits(input int n);
    int val;
    int k;
    val = 0;
    for (k = 0; k < n; k++)
    begin
      lfsr = lfsr_step(lfsr);
      val  = (val << 1) | int'(lfsr[0]);
    end
    return val;
  endfunction

  // ##################################################
  // Stimulus helpers
  // ##################################################

  task automatic load_program();
    int w;
    for (w = 0; w < IMEM_WORDS; w++)
    begin
      load_we   = 1'b1;
      load_addr = addr_t'(w) << 2;
      load_data = word_at(addr_t'(w) << 2);
      @(posedge clk);
      #1;
    end
    load_we = 1'b0;
  endtask

  // One request slot is two cycles long.
  task automatic fetch_slot(input addr_t pc, input logic miss);
    fetch_exp_s e;
    alu_vld = 1'b1;
    pc_next = pc;
    @(posedge clk);
    #1;
    e.pc     = pc;
    e.any_pc = alu_br_miss;
    e.due    = cyc + 2;
    // A request taken under a miss reads the redirect PC instead.
    if (alu_br_miss || !miss)
    begin
      exp_q.push_back(e);
    end
    alu_br_miss = 1'b0;
    @(posedge clk);
    #1;
    if (miss)
    begin
      alu_br_miss = 1'b1;
    end
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < 10)
    begin
      @(negedge clk);
      n++;
    end
    repeat (2) @(negedge clk);
    if (exp_q.size() != 0)
    begin
      errors++;
      $display("ERROR t=%0t: %0d fetches never returned", $time, exp_q.size());
      exp_q.delete();
    end
    @(posedge clk);
    #1;
  endtask

  task automatic check_count(input int got, input int want, input string what);
    if (got != want)
    begin
      errors++;
      $display("CHECK FAILED t=%0t: %0d %s results, expected %0d", $time, got, what, want);
    end
  endtask

  task automatic finish_test(input string name, input int e0, input int f0, input int p0);
    $display("test %-10s done: %0d fetches, %0d predecodes, %0d errors",
             name, fetches - f0, predecs - p0, errors - e0);
  endtask

  // ##################################################
  // Output monitor
  // ##################################################

  task automatic check_quiet();
    if (ifu_vld !== 1'b0 || predec.vld !== 1'b0)
    begin
      errors++;
      $display("CHECK FAILED t=%0t: valid output high around reset", $time);
    end
  endtask

  task automatic check_fetch();
    fetch_exp_s e;
    fetches++;
    if (exp_q.size() == 0)
    begin
      errors++;
      $display("CHECK FAILED t=%0t: unexpected fetch result pc=%h", $time, ifu_pc);
      return;
    end
    e = exp_q.pop_front();
    if (e.due != cyc)
    begin
      errors++;
      $display("CHECK FAILED t=%0t: result at cycle %0d, expected %0d", $time, cyc, e.due);
    end
    if (!e.any_pc && ifu_pc !== e.pc)
    begin
      errors++;
      $display("CHECK FAILED t=%0t: fetch pc=%h, expected %h", $time, ifu_pc, e.pc);
    end
    if (ifu_inst !== word_at(ifu_pc))
    begin
      errors++;
      $display("CHECK FAILED t=%0t: inst=%h at pc=%h, expected %h",
               $time, ifu_inst, ifu_pc, word_at(ifu_pc));
    end
  endtask

  task automatic check_predecode();
    logic [IMEM_AW-1:0] idx;
    idx = prev_pc[IMEM_AW+1:2];
    predecs++;
    if (!prev_vld)
    begin
      errors++;
      $display("CHECK FAILED t=%0t: predecode valid without a fetch result", $time);
      return;
    end
    if (predec.pc !== prev_pc || predec.inst !== prev_inst)
    begin
      errors++;
      $display("CHECK FAILED t=%0t: predecode pc/inst=%h/%h, expected %h/%h",
               $time, predec.pc, predec.inst, prev_pc, prev_inst);
    end
    if (predec.rd !== prev_inst[11:7] || predec.rs1 !== prev_inst[19:15] ||
        predec.rs2 !== prev_inst[24:20])
    begin
      errors++;
      $display("CHECK FAILED t=%0t: register fields wrong for inst=%h", $time, prev_inst);
    end
    if (idx < PROG_LEN && (predec.cls !== prog[idx].cls || predec.imm !== prog[idx].imm))
    begin
      errors++;
      $display("CHECK FAILED t=%0t: cls/imm=%0d/%h, expected %0d/%h for inst=%h", $time,
               predec.cls, predec.imm, prog[idx].cls, prog[idx].imm, prev_inst);
    end
  endtask

  always @(negedge clk)
  begin
    if (rst !== 1'b0)
    begin
      prev_vld = 1'b0;
    end
    else
    begin
      if (predec.vld === 1'b1)
      begin
        check_predecode();
      end
      else if (prev_vld)
      begin
        errors++;
        $display("ERROR t=%0t: no predecode result for pc=%h", $time, prev_pc);
      end
      while (exp_q.size() != 0 && exp_q[0].due < cyc)
      begin
        errors++;
        $display("ERROR t=%0t: fetch of pc=%h gave no result", $time, exp_q[0].pc);
        void'(exp_q.pop_front());
      end
      if (ifu_vld === 1'b1)
      begin
        check_fetch();
      end
      prev_vld  = (ifu_vld === 1'b1);
      prev_pc   = ifu_pc;
      prev_inst = ifu_inst;
    end
  end

  // ##################################################
  // Test sequence
  // ##################################################

  initial
  begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("ERROR: watchdog expired after %0d cycles, the run hung", WATCHDOG_CYCLES);
    $display("=== FAIL ===");
    $finish;
  end

  initial
  begin
    int e0;
    int f0;
    int p0;
    int i;
    int n;
    int sq;
    load_we     = 1'b0;
    load_addr   = '0;
    load_data   = '0;
    alu_vld     = 1'b0;
    alu_br_miss = 1'b0;
    pc_next     = '0;
    build_program();

    e0 = errors;
    f0 = fetches;
    p0 = predecs;
    @(negedge clk);
    while (rst === 1'b1)
    begin
      check_quiet();
      @(negedge clk);
    end
    repeat (4)
    begin
      check_quiet();
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    finish_test("reset", e0, f0, p0);

    load_program();

    e0 = errors;
    f0 = fetches;
    p0 = predecs;
    for (i = 0; i < PROG_LEN; i++)
    begin
      fetch_slot(addr_t'(i) << 2, 1'b0);
    end
    alu_vld = 1'b0;
    wait_drain();
    check_count(fetches - f0, PROG_LEN, "sequential fetch");
    finish_test("sequential", e0, f0, p0);

    // Reverse order, so every table entry passes the predecoder again.
    e0 = errors;
    f0 = fetches;
    p0 = predecs;
    for (i = 0; i < PROG_LEN; i++)
    begin
      fetch_slot(addr_t'(PROG_LEN - 1 - i) << 2, 1'b0);
    end
    alu_vld = 1'b0;
    wait_drain();
    check_count(predecs - p0, PROG_LEN, "predecode");
    finish_test("predecode", e0, f0, p0);

    e0 = errors;
    f0 = fetches;
    p0 = predecs;
    for (i = 0; i < PROG_LEN; i++)
    begin
      fetch_slot(addr_t'(i) << 2, 1'b0);
      if (i == 4 || i == 10)
      begin
        n       = take_bits(4) + 1;
        alu_vld = 1'b0;
        pc_next = PARK_PC;
        repeat (n) @(posedge clk);
        #1;
      end
    end
    alu_vld = 1'b0;
    wait_drain();
    check_count(fetches - f0, PROG_LEN, "freeze");
    finish_test("freeze", e0, f0, p0);

    // Two squashed fetches, each followed by one redirected request.
    e0 = errors;
    f0 = fetches;
    p0 = predecs;
    sq = take_bits(3) + 1;
    for (i = 0; i < PROG_LEN; i++)
    begin
      fetch_slot(addr_t'(i) << 2, (i == sq) || (i == sq + 6));
    end
    alu_vld = 1'b0;
    wait_drain();
    check_count(fetches - f0, PROG_LEN - 2, "squash");
    finish_test("squash", e0, f0, p0);

    $display("summary: %0d fetches, %0d predecodes, %0d errors", fetches, predecs, errors);
    if (errors == 0)
    begin
      $display("=== PASS ===");
    end
    else
    begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
src/fetch_pkg.sv
src/riscv_ifu.sv
src/inst_mem.sv
src/riscv_predecode.sv
src/fetch_top.sv
testbench/tb_clkgen.sv
testbench/tb_fetch.sv
